/* common/serial_consts.svh */
`ifndef SERIAL_CONSTS_SVH
`define SERIAL_CONSTS_SVH

// width of one data byte on the CDC byte streams.
`define BYTE_W 8

// counter bit that turns the pull-up on, 2^14 us at 1 MHz is about 16 ms.
`define ATTACH_LOG2_DEF 14

// counter bit that closes the attach window and switches the LED off.
`define DONE_LOG2_DEF 20

// width of the forwarded line feed counter.
`define LINE_CNT_W 16

`endif

/* common/stream_pkg.sv */
`include "serial_consts.svh"

package stream_pkg;

   // raw byte as received from the host on the out stream.
   typedef struct packed {
      logic [`BYTE_W-1:0] data;
   } byte_beat_t;

   // byte after case folding, with its classification bits.
   typedef struct packed {
      logic [`BYTE_W-1:0] data;
      logic               is_letter; // set for A-Z and a-z before folding.
      logic               is_eol;    // set for line feed.
   } folded_beat_t;

endpackage

/* common/attach_pkg.sv */
package attach_pkg;

   // attach progress as seen by the host link.
   typedef enum logic [1:0] {
      DETACHED  = 2'd0,
      ATTACHING = 2'd1,
      ATTACHED  = 2'd2
   } attach_state_e;

   typedef struct packed {
      attach_state_e state;
      logic          pu_en; // USB 1.5k pull-up enable.
      logic          led;   // status LED, on while attaching.
   } attach_status_t;

endpackage

/* attach/attach_sequencer.sv */
`timescale 1ns/1ns

`include "serial_consts.svh"

module attach_sequencer #(
   parameter int ATTACH_LOG2 = `ATTACH_LOG2_DEF,
   parameter int DONE_LOG2   = `DONE_LOG2_DEF
) (
   input  logic                       clk_1mhz,
   input  logic                       lock,
   output logic                       rstn_o,
   output attach_pkg::attach_status_t status_o
);

   import attach_pkg::*;

   logic [1:0]         rstn_sync;
   logic [DONE_LOG2:0] up_cnt;
   logic               pu_q;
   logic               cnt_done;
   attach_state_e      state;

   // lock is released asynchronously by the PLL, so the release is
   // retimed through two flops before it reaches the rest of the design.
   always_ff @(posedge clk_1mhz or negedge lock) begin
      if (!lock) begin
         rstn_sync <= 2'b00;
      end else begin
         rstn_sync <= {1'b1, rstn_sync[1]};
      end
   end

   assign rstn_o = rstn_sync[0];

   assign cnt_done = up_cnt[DONE_LOG2];

   always_ff @(posedge clk_1mhz or negedge rstn_o) begin
      if (!rstn_o) begin
         up_cnt <= '0;
         pu_q   <= 1'b0;
      end else begin
         if (up_cnt[ATTACH_LOG2]) begin
            pu_q <= 1'b1; // attach must happen within 100 ms of power good.
         end
         if (!cnt_done) begin
            up_cnt <= up_cnt + 1'b1; // stops once the done bit is reached.
         end
      end
   end

   always_comb begin
      if (!pu_q) begin
         state = DETACHED;
      end else if (!cnt_done) begin
         state = ATTACHING;
      end else begin
         state = ATTACHED;
      end
   end

   assign status_o.state = state;
   assign status_o.pu_en = pu_q;
   assign status_o.led   = ~cnt_done;

endmodule

/* design/stream_stage.sv */
`timescale 1ns/1ns

module stream_stage #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk_1mhz,
   input  logic     rstn_i,
   input  payload_t beat_i,
   input  logic     valid_i,
   output logic     ready_o,
   output payload_t beat_o,
   output logic     valid_o,
   input  logic     ready_i
);

   payload_t beat_q;
   logic     valid_q;
   logic     load;

   // the register can take a new beat when it is empty or when its
   // current beat leaves on this same edge.
   assign ready_o = ready_i | ~valid_q;
   assign load    = valid_i & ready_o;

   always_ff @(posedge clk_1mhz or negedge rstn_i) begin
      if (!rstn_i) begin
         valid_q <= 1'b0;
      end else if (ready_o) begin
         valid_q <= valid_i; // drains to empty when nothing is offered.
      end
   end

   always_ff @(posedge clk_1mhz) begin
      if (load) begin
         beat_q <= beat_i;
      end
   end

   assign beat_o  = beat_q;
   assign valid_o = valid_q;

endmodule

/* design/case_folder.sv */
`timescale 1ns/1ns

`include "serial_consts.svh"

module case_folder (
   input  logic                     clk_1mhz,
   input  logic                     rstn_i,
   input  stream_pkg::byte_beat_t   beat_i,
   input  logic                     valid_i,
   output logic                     ready_o,
   output stream_pkg::folded_beat_t beat_o,
   output logic                     valid_o,
   input  logic                     ready_i,
   output logic [`LINE_CNT_W-1:0]   line_count_o
);

   import stream_pkg::*;

   localparam logic [`BYTE_W-1:0] CHAR_UP_A   = 'h41;
   localparam logic [`BYTE_W-1:0] CHAR_UP_Z   = 'h5A;
   localparam logic [`BYTE_W-1:0] CHAR_LO_A   = 'h61;
   localparam logic [`BYTE_W-1:0] CHAR_LO_Z   = 'h7A;
   localparam logic [`BYTE_W-1:0] CHAR_LF     = 'h0A;
   localparam logic [`BYTE_W-1:0] CASE_OFFSET = 'h20;

   logic                   is_upper;
   logic                   is_lower;
   folded_beat_t           folded;
   logic [`LINE_CNT_W-1:0] line_cnt;

   assign is_upper = (beat_i.data >= CHAR_UP_A) && (beat_i.data <= CHAR_UP_Z);
   assign is_lower = (beat_i.data >= CHAR_LO_A) && (beat_i.data <= CHAR_LO_Z);

   // lower case letters sit 0x20 above their upper case partners.
   always_comb begin
      folded.data      = is_lower ? (beat_i.data - CASE_OFFSET) : beat_i.data;
      folded.is_letter = is_upper | is_lower;
      folded.is_eol    = (beat_i.data == CHAR_LF);
   end

   stream_stage #(
      .payload_t(folded_beat_t)
   ) u_fold_stage (
      .clk_1mhz(clk_1mhz),
      .rstn_i  (rstn_i),
      .beat_i  (folded),
      .valid_i (valid_i),
      .ready_o (ready_o),
      .beat_o  (beat_o),
      .valid_o (valid_o),
      .ready_i (ready_i)
   );

   // a line is counted when its line feed is actually handed to the host.
   always_ff @(posedge clk_1mhz or negedge rstn_i) begin
      if (!rstn_i) begin
         line_cnt <= '0;
      end else if (valid_o && ready_i && beat_o.is_eol) begin
         line_cnt <= line_cnt + 1'b1;
      end
   end

   assign line_count_o = line_cnt;

endmodule

/* design/echo_top.sv */
`timescale 1ns/1ns

`include "serial_consts.svh"

module echo_top #(
   parameter int ATTACH_LOG2 = `ATTACH_LOG2_DEF,
   parameter int DONE_LOG2   = `DONE_LOG2_DEF
) (
   input  logic                     clk_1mhz,
   input  logic                     lock,
   input  stream_pkg::byte_beat_t   out_beat_i,
   input  logic                     out_valid_i,
   output logic                     out_ready_o,
   output stream_pkg::folded_beat_t in_beat_o,
   output logic                     in_valid_o,
   input  logic                     in_ready_i,
   output logic                     usb_pu_o,
   output logic                     led_o,
   output logic [`LINE_CNT_W-1:0]   line_count_o
);

   import stream_pkg::*;
   import attach_pkg::*;

   logic           rstn;
   attach_status_t attach_status;
   logic           rx_valid_in;
   logic           rx_ready_out;
   byte_beat_t     rx_beat;
   logic           rx_valid;
   logic           rx_ready;

   attach_sequencer #(
      .ATTACH_LOG2(ATTACH_LOG2),
      .DONE_LOG2  (DONE_LOG2)
   ) u_attach (
      .clk_1mhz(clk_1mhz),
      .lock    (lock),
      .rstn_o  (rstn),
      .status_o(attach_status)
   );

   // the host cannot send anything before the pull-up is on, so the
   // stream entry stays closed until then.
   assign rx_valid_in = out_valid_i & attach_status.pu_en;
   assign out_ready_o = rx_ready_out & attach_status.pu_en;

   stream_stage #(
      .payload_t(byte_beat_t)
   ) u_rx_stage (
      .clk_1mhz(clk_1mhz),
      .rstn_i  (rstn),
      .beat_i  (out_beat_i),
      .valid_i (rx_valid_in),
      .ready_o (rx_ready_out),
      .beat_o  (rx_beat),
      .valid_o (rx_valid),
      .ready_i (rx_ready)
   );

   case_folder u_case_folder (
      .clk_1mhz    (clk_1mhz),
      .rstn_i      (rstn),
      .beat_i      (rx_beat),
      .valid_i     (rx_valid),
      .ready_o     (rx_ready),
      .beat_o      (in_beat_o),
      .valid_o     (in_valid_o),
      .ready_i     (in_ready_i),
      .line_count_o(line_count_o)
   );

   assign usb_pu_o = (attach_status.state != DETACHED);
   assign led_o    = attach_status.led; // on during attach, off for good after.

endmodule

/* dv/echo_tb.sv */
`timescale 1ns/1ns

`include "serial_consts.svh"

module echo_tb;

   import stream_pkg::*;

   localparam int CLK_PERIOD      = 10;
   localparam int ATTACH_LOG2_TB  = 4;
   localparam int DONE_LOG2_TB    = 6;
   localparam int SYNC_EDGES      = 2;
   localparam int PU_EDGE         = SYNC_EDGES + (1 << ATTACH_LOG2_TB) + 1;
   localparam int LED_EDGE        = SYNC_EDGES + (1 << DONE_LOG2_TB);
   localparam int FOLD_BEATS      = 96;
   localparam int RANDOM_BEATS    = 200;
   localparam int NUM_LINES       = 12;
   localparam int LINE_LEN        = 5;
   localparam int TOTAL_BEATS     = FOLD_BEATS + RANDOM_BEATS + NUM_LINES * LINE_LEN;
   localparam int WATCHDOG_CYCLES = 2 * (LED_EDGE + 10) + 20 * TOTAL_BEATS + 500;

   logic                   clk_1mhz;
   logic                   lock;
   byte_beat_t             out_beat;
   logic                   out_valid;
   logic                   out_ready;
   folded_beat_t           in_beat;
   logic                   in_valid;
   logic                   in_ready;
   logic                   usb_pu;
   logic                   led;
   logic [`LINE_CNT_W-1:0] line_count;

   folded_beat_t           exp_q[$];
   int                     accepted       = 0;
   int                     delivered      = 0;
   int                     err_cnt        = 0;
   int                     stream_err_cnt = 0;
   int                     tests_passed   = 0;
   int                     tests_failed   = 0;
   integer                 seed;
   integer                 rnd_data;
   integer                 rnd_rdy;
   logic                   sends_done;
   logic [`LINE_CNT_W-1:0] lf_sent;

   echo_top #(
      .ATTACH_LOG2(ATTACH_LOG2_TB),
      .DONE_LOG2  (DONE_LOG2_TB)
   ) uut (
      .clk_1mhz    (clk_1mhz),
      .lock        (lock),
      .out_beat_i  (out_beat),
      .out_valid_i (out_valid),
      .out_ready_o (out_ready),
      .in_beat_o   (in_beat),
      .in_valid_o  (in_valid),
      .in_ready_i  (in_ready),
      .usb_pu_o    (usb_pu),
      .led_o       (led),
      .line_count_o(line_count)
   );

   initial begin
      clk_1mhz = 1'b0;
      forever #(CLK_PERIOD / 2) clk_1mhz = ~clk_1mhz;
   end

   // expected output for one byte sent by the host.
   function automatic folded_beat_t fold_ref(input logic [`BYTE_W-1:0] b);
      folded_beat_t r;
      logic         lower;
      lower       = (b >= 8'h61) && (b <= 8'h7A);
      r.is_letter = lower || ((b >= 8'h41) && (b <= 8'h5A));
      r.is_eol    = (b == 8'h0A);
      r.data      = lower ? (b ^ 8'h20) : b; // bit 5 is the case bit in ASCII.
      return r;
   endfunction

   function automatic int total_errors();
      return err_cnt + stream_err_cnt;
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
         err_cnt = err_cnt + 1;
      end
   endtask

   task automatic check_count(input string name, input logic [`LINE_CNT_W-1:0] got,
                              input logic [`LINE_CNT_W-1:0] exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
         err_cnt = err_cnt + 1;
      end
   endtask

   task automatic check_beat(input string name, input folded_beat_t got,
                             input folded_beat_t exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
         stream_err_cnt = stream_err_cnt + 1;
      end
   endtask

   // every accepted out beat queues its expected result, every in beat pops one.
   always @(posedge clk_1mhz) begin
      if (out_valid && out_ready) begin
         exp_q.push_back(fold_ref(out_beat.data));
         accepted = accepted + 1;
      end
      if (in_valid && in_ready) begin
         if (exp_q.size() == 0) begin
            $display("in stream delivered beat %h with no beat outstanding", in_beat);
            stream_err_cnt = stream_err_cnt + 1;
         end else begin
            check_beat("in_beat_o", in_beat, exp_q.pop_front());
         end
         delivered = delivered + 1;
      end
      if (accepted - delivered > 2) begin
         $display("pipeline holds %0d beats, more than its two stages", accepted - delivered);
         stream_err_cnt = stream_err_cnt + 1;
      end
   end

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   task report_test(input string name, input int errs_at_start);
      if (total_errors() == errs_at_start) begin
         $display("test %s: pass", name);
         tests_passed = tests_passed + 1;
      end else begin
         $display("test %s: fail with %0d errors", name, total_errors() - errs_at_start);
         tests_failed = tests_failed + 1;
      end
   endtask

   // called on a falling edge, returns on the falling edge after the transfer.
   task send_byte(input logic [`BYTE_W-1:0] b);
      out_beat.data = b;
      out_valid     = 1'b1;
      do @(posedge clk_1mhz); while (!out_ready);
      if (b == 8'h0A) lf_sent = lf_sent + 1'b1;
      @(negedge clk_1mhz);
      out_valid = 1'b0;
   endtask

   task wait_drain(input int max_cycles);
      int n;
      n = 0;
      while ((exp_q.size() != 0 || in_valid) && n < max_cycles) begin
         @(negedge clk_1mhz);
         n = n + 1;
      end
      if (exp_q.size() != 0 || in_valid) begin
         $display("pipeline still holds beats %0d cycles after the last send", max_cycles);
         err_cnt = err_cnt + 1;
      end
   endtask

   task attach_test;
      int errs;
      int edge_n;
      errs = total_errors();
      repeat (2) @(negedge clk_1mhz);
      check_bit("usb_pu_o", usb_pu, 1'b0);
      check_bit("led_o", led, 1'b1);
      check_bit("out_ready_o", out_ready, 1'b0);
      check_bit("in_valid_o", in_valid, 1'b0);
      check_count("line_count_o", line_count, '0);
      lock = 1'b1;
      for (edge_n = 1; edge_n <= LED_EDGE + 8; edge_n++) begin
         @(negedge clk_1mhz);
         check_bit("usb_pu_o", usb_pu, edge_n >= PU_EDGE);
         check_bit("led_o", led, edge_n < LED_EDGE);
      end
      report_test("1 attach sequence", errs);
   endtask

   task intake_test;
      int errs;
      int n;
      errs = total_errors();
      lock          = 1'b0; // lock loss restarts the whole attach.
      out_beat.data = 8'h61;
      out_valid     = 1'b1;
      repeat (2) @(negedge clk_1mhz);
      lock = 1'b1;
      n    = 0;
      while (!usb_pu && n < PU_EDGE + 8) begin
         check_bit("out_ready_o", out_ready, 1'b0);
         check_bit("in_valid_o", in_valid, 1'b0);
         @(negedge clk_1mhz);
         n = n + 1;
      end
      out_valid = 1'b0;
      if (!usb_pu) begin
         $display("usb_pu_o did not rise within %0d cycles of lock", PU_EDGE + 8);
         err_cnt = err_cnt + 1;
      end
      if (accepted != 0) begin
         $display("%0d beats were taken before the pull-up was on", accepted);
         err_cnt = err_cnt + 1;
      end
      report_test("2 no intake before attach", errs);
   endtask

   task folding_test;
      int errs;
      int code;
      errs = total_errors();
      for (code = 32; code <= 126; code++) begin
         send_byte(code[7:0]);
      end
      send_byte(8'h0A);
      wait_drain(50);
      report_test("3 case folding", errs);
   endtask

   task backpressure_test;
      int                 errs;
      int                 i;
      logic [`BYTE_W-1:0] tx_bytes [RANDOM_BEATS];
      errs       = total_errors();
      sends_done = 1'b0;
      // the data is drawn up front, so only the ready toggling draws while sending.
      for (i = 0; i < RANDOM_BEATS; i++) begin
         rnd_data    = $random(seed);
         tx_bytes[i] = rnd_data[7:0];
      end
      fork
         begin
            for (i = 0; i < RANDOM_BEATS; i++) begin
               send_byte(tx_bytes[i]);
            end
            sends_done = 1'b1;
         end
         begin
            while (!sends_done) begin
               @(negedge clk_1mhz);
               rnd_rdy  = $random(seed);
               in_ready = rnd_rdy[0];
            end
         end
      join
      in_ready = 1'b1;
      wait_drain(50);
      report_test("4 back-pressure", errs);
   endtask

   task line_count_test;
      int errs;
      int line;
      int k;
      errs = total_errors();
      for (line = 0; line < NUM_LINES; line++) begin
         for (k = 0; k < LINE_LEN - 1; k++) begin
            rnd_data = {$random(seed)} % 95;
            send_byte(8'(rnd_data + 32)); // printable only, so no stray line feeds.
         end
         send_byte(8'h0A);
      end
      wait_drain(50);
      check_count("line_count_o", line_count, lf_sent);
      report_test("5 line count", errs);
   endtask

   initial begin
      seed       = 486;
      lock       = 1'b0;
      out_beat   = '0;
      out_valid  = 1'b0;
      in_ready   = 1'b1;
      sends_done = 1'b0;
      lf_sent    = '0;
      attach_test();
      intake_test();
      folding_test();
      backpressure_test();
      line_count_test();
      $display("%0d tests run, %0d passed, %0d failed, %0d errors, %0d beats checked",
               tests_passed + tests_failed, tests_passed, tests_failed, total_errors(),
               delivered);
      if (total_errors() == 0 && tests_failed == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+common
common/stream_pkg.sv
common/attach_pkg.sv
attach/attach_sequencer.sv
design/stream_stage.sv
design/case_folder.sv
design/echo_top.sv
dv/echo_tb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module echo_tb -o echo_sim

./obj_dir/echo_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   echo "run.sh: simulation passed"
   exit 0
else
   echo "run.sh: simulation did not pass, see sim.log"
   exit 1
fi
